// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int ADDR_WIDTH = 64;                 // pc and byte addresses
	localparam int INST_WIDTH = 32;                 // one instruction
	localparam int LINE_WIDTH = 64;                 // two instructions per line
	localparam int LINE_OFFSET_BITS = 3;            // byte offset inside a line

	// instruction cache geometry
	localparam int ICACHE_INDEX_BITS = 4;
	localparam int ICACHE_LINES = 1 << ICACHE_INDEX_BITS;
	localparam int TAG_WIDTH = ADDR_WIDTH - ICACHE_INDEX_BITS - LINE_OFFSET_BITS; // pc[63:7]

	// backing memory, upper address bits ignored so it wraps
	localparam int MEM_INDEX_BITS = 8;
	localparam int MEM_LINES = 1 << MEM_INDEX_BITS;
	localparam int MEM_LATENCY = 4;                 // request to valid, in cycles

	// branch format
	localparam int BR_DISP_BITS = 21;               // signed word displacement in [20:0]

	////////////////////////////////////////////////////////////////////////////
	// enums
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic {
		bus_none,                                   // no request this cycle
		bus_load                                    // read line at addr
	} bus_command_t;

	// opcode field is inst[31:26]
	typedef enum logic [5:0] {
		op_other = 6'h00,                           // anything that is not br
		op_br    = 6'h30                            // unconditional branch
	} opcode_t;

	typedef enum logic {
		cache_idle,
		cache_refill                                // waiting on backing memory
	} cache_state_t;

endpackage

// ==== design/fetch_ifs.sv ====
`timescale 1ns/1ps

// fetch stage <-> instruction cache, hit is combinational on addr
interface icache_if;
	logic [fetch_pkg::ADDR_WIDTH-1:0] addr;         // pc aligned down to 8
	fetch_pkg::bus_command_t          command;
	logic [fetch_pkg::LINE_WIDTH-1:0] data;         // line at addr
	logic                             hit;          // only meaningful on bus_load

	modport fetch (output addr, output command, input data, input hit);
	modport cache (input addr, input command, output data, output hit);
endinterface

// instruction cache <-> backing memory
// one cycle request pulse, valid pulses MEM_LATENCY cycles later
interface mem_if;
	logic                                 request;
	logic [fetch_pkg::MEM_INDEX_BITS-1:0] line_addr;
	logic [fetch_pkg::LINE_WIDTH-1:0]     data;
	logic                                 valid;

	modport cache (output request, output line_addr, input data, input valid);
	modport memory (input request, input line_addr, output data, output valid);
endinterface

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
	input  logic                                clock,
	input  logic                                reset,
	input  logic                                rs_stall,      // reservation station full
	input  logic                                rob_stall,     // reorder buffer full
	input  logic                                rat_stall,     // free list empty
	input  logic                                structure_hazard_stall,
	input  logic                                mispredict,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0]    target_pc,
	input  logic                                uncond1,       // br in slot 1
	input  logic                                uncond2,       // br in slot 2
	input  logic [fetch_pkg::ADDR_WIDTH-1:0]    target1,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0]    target2,
	icache_if.fetch                             cache,
	output logic [fetch_pkg::INST_WIDTH-1:0]    inst1,
	output logic [fetch_pkg::INST_WIDTH-1:0]    inst2,
	output logic                                inst1_valid,
	output logic                                inst2_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0]    fetch_pc
);

	logic [fetch_pkg::ADDR_WIDTH-1:0] pc;
	logic [fetch_pkg::ADDR_WIDTH-1:0] next_pc;
	fetch_pkg::bus_command_t          next_command;
	logic                             reset_follow;  // first cycle out of reset
	logic                             stall;
	logic                             fetch_hit;     // hit on a real load
	logic [fetch_pkg::INST_WIDTH-1:0] slot1;
	logic [fetch_pkg::INST_WIDTH-1:0] slot2;

	assign stall = rs_stall || rob_stall || rat_stall || structure_hazard_stall;
	assign fetch_hit = cache.hit && (cache.command == fetch_pkg::bus_load);

	assign cache.addr = {pc[fetch_pkg::ADDR_WIDTH-1:fetch_pkg::LINE_OFFSET_BITS],
		{fetch_pkg::LINE_OFFSET_BITS{1'b0}}};
	assign slot1 = cache.data[fetch_pkg::INST_WIDTH-1:0];          // lower word
	assign slot2 = cache.data[fetch_pkg::LINE_WIDTH-1:fetch_pkg::INST_WIDTH];
	assign fetch_pc = pc;

	////////////////////////////////////////////////////////////////////////////
	// pc, command and reset-follow registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			pc            <= '0;
			cache.command <= fetch_pkg::bus_none;
			reset_follow  <= 1'b1;
		end
		else
		begin
			pc            <= next_pc;
			cache.command <= next_command;
			reset_follow  <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next pc and slot outputs
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		next_pc      = pc;                       // hold by default
		next_command = fetch_pkg::bus_load;
		inst1        = '0;
		inst2        = '0;
		inst1_valid  = 1'b0;
		inst2_valid  = 1'b0;
		if (mispredict)
		begin
			next_pc = target_pc;                 // nothing delivered this cycle
		end
		else if (reset_follow)
		begin
			next_pc = pc;                        // start loading at reset pc
		end
		else if (fetch_hit && !stall)
		begin
			if (pc[2])
			begin
				// pc at 8n+4, only the upper word is ours
				inst1       = slot2;
				inst1_valid = 1'b1;
				next_pc     = uncond2 ? target2 : pc + 4;
			end
			else
			begin
				inst1       = slot1;
				inst1_valid = 1'b1;
				if (uncond1)
				begin
					next_pc = target1;           // slot 2 is on the wrong path
				end
				else
				begin
					inst2       = slot2;
					inst2_valid = 1'b1;
					next_pc     = uncond2 ? target2 : pc + 8;
				end
			end
		end
		else if (!cache.hit && stall)
		begin
			next_command = fetch_pkg::bus_none;  // no new refill while stalled
		end
	end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/1ps

module icache (
	input  logic clock,
	input  logic reset,
	icache_if.cache fetch,
	mem_if.cache    mem
);

	localparam int IDX = fetch_pkg::ICACHE_INDEX_BITS;
	localparam int OFS = fetch_pkg::LINE_OFFSET_BITS;

	////////////////////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////////////////////

	logic [fetch_pkg::ICACHE_LINES-1:0] valid_bits;
	logic [fetch_pkg::TAG_WIDTH-1:0]    tag_array [fetch_pkg::ICACHE_LINES];
	logic [fetch_pkg::LINE_WIDTH-1:0]   data_array [fetch_pkg::ICACHE_LINES];

	fetch_pkg::cache_state_t            state;

	logic [IDX-1:0]                     index;          // from fetch addr
	logic [fetch_pkg::TAG_WIDTH-1:0]    tag;
	logic [IDX-1:0]                     refill_index;   // line being refilled
	logic [fetch_pkg::TAG_WIDTH-1:0]    refill_tag;
	logic                               start_refill;
	logic                               fill_done;

	assign index = fetch.addr[OFS +: IDX];
	assign tag   = fetch.addr[fetch_pkg::ADDR_WIDTH-1 -: fetch_pkg::TAG_WIDTH];

	// same cycle lookup
	assign fetch.hit  = valid_bits[index] && (tag_array[index] == tag);
	assign fetch.data = data_array[index];

	// only a real load that misses while idle goes to memory
	assign start_refill = (state == fetch_pkg::cache_idle)
		&& (fetch.command == fetch_pkg::bus_load) && !fetch.hit;
	assign fill_done = (state == fetch_pkg::cache_refill) && mem.valid;

	////////////////////////////////////////////////////////////////////////////
	// refill state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state       <= fetch_pkg::cache_idle;
			valid_bits  <= '0;
			mem.request <= 1'b0;
		end
		else
		begin
			mem.request <= 1'b0;                     // single cycle pulse
			case (state)
				fetch_pkg::cache_idle:
				begin
					if (start_refill)
					begin
						mem.request <= 1'b1;
						state       <= fetch_pkg::cache_refill;
					end
				end
				fetch_pkg::cache_refill:
				begin
					if (fill_done)
					begin
						valid_bits[refill_index] <= 1'b1;
						state                    <= fetch_pkg::cache_idle;
					end
				end
				default:
				begin
					state <= fetch_pkg::cache_idle;
				end
			endcase
		end
	end

	// refill bookkeeping, captured with the request
	always_ff @(posedge clock)
	begin
		if (start_refill)
		begin
			refill_index  <= index;
			refill_tag    <= tag;
			mem.line_addr <= fetch.addr[OFS +: fetch_pkg::MEM_INDEX_BITS]; // wraps
		end
	end

	// arrays written on the edge that ends the valid cycle
	always_ff @(posedge clock)
	begin
		if (fill_done)
		begin
			tag_array[refill_index]  <= refill_tag;
			data_array[refill_index] <= mem.data;
		end
	end

endmodule

// ==== design/inst_memory.sv ====
`timescale 1ns/1ps

module inst_memory (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 write_enable,  // preload strobe
	input  logic [fetch_pkg::MEM_INDEX_BITS-1:0] write_addr,
	input  logic [fetch_pkg::LINE_WIDTH-1:0]     write_data,
	mem_if.memory                                port
);

	localparam int LAT = fetch_pkg::MEM_LATENCY;

	logic [fetch_pkg::LINE_WIDTH-1:0] lines [fetch_pkg::MEM_LINES];
	logic [LAT-1:0]                   valid_pipe;       // one bit per stage
	logic [fetch_pkg::LINE_WIDTH-1:0] data_pipe [LAT];

	////////////////////////////////////////////////////////////////////////////
	// line storage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (write_enable)
		begin
			lines[write_addr] <= write_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// fixed latency read pipe
	////////////////////////////////////////////////////////////////////////////

	// valid shifts along, several reads may be in flight
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_pipe <= '0;
		end
		else
		begin
			valid_pipe <= {valid_pipe[LAT-2:0], port.request};
		end
	end

	// read captured at the request edge, payload just follows
	always_ff @(posedge clock)
	begin
		data_pipe[0] <= lines[port.line_addr];
		for (int i = 1; i < LAT; i++)
		begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign port.valid = valid_pipe[LAT-1];
	assign port.data  = data_pipe[LAT-1];                // only looked at with valid

endmodule

// ==== design/branch_predecode.sv ====
`timescale 1ns/1ps

module branch_predecode (
	input  logic [fetch_pkg::LINE_WIDTH-1:0] line,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0] line_pc,    // aligned to 8
	output logic                             uncond1,
	output logic                             uncond2,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] target1,
	output logic [fetch_pkg::ADDR_WIDTH-1:0] target2
);

	localparam int IW  = fetch_pkg::INST_WIDTH;
	localparam int DB  = fetch_pkg::BR_DISP_BITS;
	localparam int EXT = fetch_pkg::ADDR_WIDTH - DB - 2; // sign bits above disp*4

	logic [IW-1:0]                    inst_a;            // slot 1, lower word
	logic [IW-1:0]                    inst_b;            // slot 2, upper word
	fetch_pkg::opcode_t               op_a;
	fetch_pkg::opcode_t               op_b;
	logic [fetch_pkg::ADDR_WIDTH-1:0] offset_a;          // byte offset
	logic [fetch_pkg::ADDR_WIDTH-1:0] offset_b;
	logic [fetch_pkg::ADDR_WIDTH-1:0] pc_b;

	assign inst_a = line[IW-1:0];
	assign inst_b = line[2*IW-1:IW];

	// anything but br folds to op_other
	assign op_a = (inst_a[31:26] == fetch_pkg::op_br) ? fetch_pkg::op_br : fetch_pkg::op_other;
	assign op_b = (inst_b[31:26] == fetch_pkg::op_br) ? fetch_pkg::op_br : fetch_pkg::op_other;

	assign uncond1 = (op_a == fetch_pkg::op_br);
	assign uncond2 = (op_b == fetch_pkg::op_br);

	// word displacement, sign extended and scaled to bytes
	assign offset_a = {{EXT{inst_a[DB-1]}}, inst_a[DB-1:0], 2'b00};
	assign offset_b = {{EXT{inst_b[DB-1]}}, inst_b[DB-1:0], 2'b00};

	assign pc_b = line_pc + 4;                           // slot 2 address

	// relative to the instruction after the branch
	assign target1 = line_pc + 4 + offset_a;
	assign target2 = pc_b + 4 + offset_b;

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
	input  logic                                 clock,
	input  logic                                 reset,
	input  logic                                 rs_stall,
	input  logic                                 rob_stall,
	input  logic                                 rat_stall,
	input  logic                                 structure_hazard_stall,
	input  logic                                 mispredict,
	input  logic [fetch_pkg::ADDR_WIDTH-1:0]     target_pc,
	input  logic                                 mem_write_enable,   // preload port
	input  logic [fetch_pkg::MEM_INDEX_BITS-1:0] mem_write_addr,
	input  logic [fetch_pkg::LINE_WIDTH-1:0]     mem_write_data,
	output logic [fetch_pkg::INST_WIDTH-1:0]     inst1,
	output logic [fetch_pkg::INST_WIDTH-1:0]     inst2,
	output logic                                 inst1_valid,
	output logic                                 inst2_valid,
	output logic [fetch_pkg::ADDR_WIDTH-1:0]     fetch_pc
);

	icache_if cache_bus ();
	mem_if    mem_bus ();

	// predecode results
	logic                             uncond1;
	logic                             uncond2;
	logic [fetch_pkg::ADDR_WIDTH-1:0] target1;
	logic [fetch_pkg::ADDR_WIDTH-1:0] target2;

	fetch_stage u_fetch_stage (
		.clock                  (clock),
		.reset                  (reset),
		.rs_stall               (rs_stall),
		.rob_stall              (rob_stall),
		.rat_stall              (rat_stall),
		.structure_hazard_stall (structure_hazard_stall),
		.mispredict             (mispredict),
		.target_pc              (target_pc),
		.uncond1                (uncond1),
		.uncond2                (uncond2),
		.target1                (target1),
		.target2                (target2),
		.cache                  (cache_bus.fetch),
		.inst1                  (inst1),
		.inst2                  (inst2),
		.inst1_valid            (inst1_valid),
		.inst2_valid            (inst2_valid),
		.fetch_pc               (fetch_pc)
	);

	icache u_icache (
		.clock (clock),
		.reset (reset),
		.fetch (cache_bus.cache),
		.mem   (mem_bus.cache)
	);

	inst_memory u_inst_memory (
		.clock        (clock),
		.reset        (reset),
		.write_enable (mem_write_enable),
		.write_addr   (mem_write_addr),
		.write_data   (mem_write_data),
		.port         (mem_bus.memory)
	);

	// sees the same line and aligned pc as the fetch stage
	branch_predecode u_branch_predecode (
		.line    (cache_bus.data),
		.line_pc (cache_bus.addr),
		.uncond1 (uncond1),
		.uncond2 (uncond2),
		.target1 (target1),
		.target2 (target2)
	);

endmodule

// ==== testbench/fetch_checker.sv ====
`timescale 1ns/1ps

// follows the fetch output and predicts every slot from the program copy in fetch_tb
module fetch_checker (
	input logic                             clock,
	input logic                             reset,
	input logic                             rs_stall,
	input logic                             rob_stall,
	input logic                             rat_stall,
	input logic                             structure_hazard_stall,
	input logic                             mispredict,
	input logic [fetch_pkg::ADDR_WIDTH-1:0] target_pc,
	input logic [fetch_pkg::INST_WIDTH-1:0] inst1,
	input logic [fetch_pkg::INST_WIDTH-1:0] inst2,
	input logic                             inst1_valid,
	input logic                             inst2_valid,
	input logic [fetch_pkg::ADDR_WIDTH-1:0] fetch_pc
);

	string                            test_name = "startup";
	int                               error_count = 0;    // every mismatch so far
	int                               observed = 0;       // instructions since last redirect
	int                               first_latency = -1; // cycles to first delivery
	int                               base_errors = 0;
	int                               passed = 0;
	int                               failed = 0;
	int                               cycle_errors;
	int                               since_redirect;
	logic [fetch_pkg::ADDR_WIDTH-1:0] expected_pc;        // next pc the stream must show

	// byte address bits [6:3] pick one of the 16 program lines
	function automatic logic [31:0] word_at(input logic [63:0] addr);
		logic [63:0] line;
		line = fetch_tb.program_lines[addr[6:3]];
		return addr[2] ? line[63:32] : line[31:0];      // upper word sits at +4
	endfunction

	function automatic logic is_branch(input logic [31:0] word);
		return word[31:26] == fetch_pkg::op_br;
	endfunction

	// own address + 4 + 4 * signed word displacement
	function automatic logic [63:0] branch_dest(input logic [63:0] addr, input logic [31:0] word);
		logic signed [63:0] words;
		words = $signed(word[20:0]);                    // sign extends to 64 bits
		return addr + 64'd4 + words * 4;
	endfunction

	task automatic mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("[FAIL] %s %s expected %0h actual %0h", test_name, what, expected, actual);
		cycle_errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per cycle comparison at the edge that ends the cycle
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clock)
	begin : sample
		logic [31:0] exp1;
		logic [31:0] exp2;
		logic        exp2_valid;
		logic [63:0] next_pc;
		cycle_errors = 0;
		if (reset)
		begin
			expected_pc = '0;                           // pc leaves reset at 0
			since_redirect = 0;
		end
		else if (mispredict || rs_stall || rob_stall || rat_stall || structure_hazard_stall)
		begin
			// both slots stay quiet on a redirect or back-pressure
			if (inst1_valid || inst2_valid)
				mismatch("valids", 64'd0, {62'd0, inst2_valid, inst1_valid});
			if (mispredict)
			begin
				expected_pc = target_pc;
				since_redirect = 0;
				first_latency <= -1;
				observed <= 0;
			end
			else
				since_redirect++;
		end
		else
		begin
			since_redirect++;
			if (inst1_valid)
			begin
				if (fetch_pc !== expected_pc)
					mismatch("fetch_pc", expected_pc, fetch_pc);
				exp1 = word_at(expected_pc);
				exp2 = word_at(expected_pc + 64'd4);
				exp2_valid = !expected_pc[2] && !is_branch(exp1);   // pair only when aligned
				if (!exp2_valid)
					next_pc = is_branch(exp1) ? branch_dest(expected_pc, exp1) : expected_pc + 4;
				else
					next_pc = is_branch(exp2) ? branch_dest(expected_pc + 4, exp2)
						: expected_pc + 8;
				if (inst1 !== exp1)
					mismatch("inst1", exp1, inst1);
				if (inst2_valid !== exp2_valid)
					mismatch("inst2_valid", exp2_valid, inst2_valid);
				else if (exp2_valid && inst2 !== exp2)
					mismatch("inst2", exp2, inst2);
				expected_pc = next_pc;
				observed <= observed + (exp2_valid ? 2 : 1);
				if (first_latency < 0)
					first_latency <= since_redirect;
			end
			else if (inst2_valid)
				mismatch("inst2_valid", 64'd0, 64'd1);  // slot 2 never alone
		end
		error_count <= error_count + cycle_errors;
	end

	////////////////////////////////////////////////////////////////////////////
	// test bookkeeping driven from fetch_tb
	////////////////////////////////////////////////////////////////////////////

	task automatic start_test(input string name);
		test_name <= name;
		base_errors = error_count;
	endtask

	task automatic finish_test(input logic timed_out, input int wanted, input int min_latency);
		logic ok;
		ok = !timed_out && (error_count == base_errors);
		if (timed_out)
			$display("%s: timed out with %0d of %0d instructions seen", test_name, observed, wanted);
		if (min_latency > 0 && first_latency < min_latency)
		begin
			// a cold line has to come through a refill first
			$display("[FAIL] %s first_latency expected >= %0d actual %0d", test_name,
				min_latency, first_latency);
			ok = 1'b0;
		end
		if (ok)
			passed++;
		else
			failed++;
		$display("%s: %s, %0d mismatches", test_name, ok ? "ok" : "failed",
			error_count - base_errors);
	endtask

	task automatic report_counts();
		$display("%0d tests, %0d ok, %0d failed, %0d mismatches in total", passed + failed,
			passed, failed, error_count);
	endtask

endmodule

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

	localparam int PROGRAM_LINES = 16;      // one line preloaded per reset cycle
	localparam int NUM_TESTS     = 10;
	localparam int TEST_TIMEOUT  = 200;     // cycles allowed per table entry

	logic                                 clock = 1'b0;
	logic                                 reset = 1'b1;
	logic                                 rs_stall = 1'b0;
	logic                                 rob_stall = 1'b0;
	logic                                 rat_stall = 1'b0;
	logic                                 structure_hazard_stall = 1'b0;
	logic                                 mispredict = 1'b0;
	logic [fetch_pkg::ADDR_WIDTH-1:0]     target_pc = '0;
	logic                                 mem_write_enable = 1'b0;
	logic [fetch_pkg::MEM_INDEX_BITS-1:0] mem_write_addr = '0;
	logic [fetch_pkg::LINE_WIDTH-1:0]     mem_write_data = '0;
	logic [fetch_pkg::INST_WIDTH-1:0]     inst1;
	logic [fetch_pkg::INST_WIDTH-1:0]     inst2;
	logic                                 inst1_valid;
	logic                                 inst2_valid;
	logic [fetch_pkg::ADDR_WIDTH-1:0]     fetch_pc;

	logic [63:0] program_lines [PROGRAM_LINES];     // copy of what goes into inst_memory

	// scenario table, one column per array
	string       names [NUM_TESTS];
	logic [63:0] starts [NUM_TESTS];                // redirect target
	int          counts [NUM_TESTS];                // instructions to observe
	int          stall_at [NUM_TESTS];              // cycle the stall window opens
	int          stall_len [NUM_TESTS];             // 0 means no stall
	int          min_latency [NUM_TESTS];           // 0 means not checked
	int          seed = 12339;

	always #5 clock = ~clock;

	fetch_top DUT (.*);

	fetch_checker CHK (.*);

	// opcode 01 and a body scrambled from the full word address
	function automatic logic [31:0] plain_word(input int word_addr);
		logic [25:0] body;
		body = 26'(word_addr * 32'h0002_9e37 + 32'h0001_5a3c);
		return {6'h01, body};
	endfunction

	function automatic logic [31:0] branch_word(input logic [63:0] at, input logic [63:0] dest);
		logic signed [63:0] delta;
		delta = $signed(dest - at - 64'd4) >>> 2;       // in words
		return {fetch_pkg::op_br, 5'd0, delta[20:0]};
	endfunction

	// closed loop program, nothing reachable leaves the 16 lines
	task automatic build_program();
		logic [31:0] words [2*PROGRAM_LINES];
		for (int w = 0; w < 2 * PROGRAM_LINES; w++)
			words[w] = plain_word(w);
		words['h20/4] = branch_word(64'h20, 64'h2c);    // slot 1, lands on 8n+4
		words['h34/4] = branch_word(64'h34, 64'h40);    // slot 2, forward
		words['h7c/4] = branch_word(64'h7c, 64'h00);    // slot 2, back to the top
		for (int l = 0; l < PROGRAM_LINES; l++)
			program_lines[l] = {words[2*l+1], words[2*l]};
	endtask

	task automatic set_entry(input int i, input string name, input logic [63:0] start,
		input int count, input int at, input int len, input int latency);
		names[i]       = name;
		starts[i]      = start;
		counts[i]      = count;
		stall_at[i]    = at;
		stall_len[i]   = len;
		min_latency[i] = latency;
	endtask

	task automatic drive_stall(input int source, input logic level);
		case (source)
			0: rs_stall <= level;
			1: rob_stall <= level;
			2: rat_stall <= level;
			default: structure_hazard_stall <= level;
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reset with preload, then the table
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int   source;
		int   cycle;
		logic done;
		build_program();
		set_entry(0, "cold_start", 64'h48, 6, 0, 0, fetch_pkg::MEM_LATENCY + 2);
		set_entry(1, "sequential_lines", 64'h00, 12, 0, 0, 0);
		set_entry(2, "odd_target", 64'h0c, 5, 0, 0, 0);
		set_entry(3, "branch_slot1", 64'h18, 6, 0, 0, 0);
		set_entry(4, "branch_slot2", 64'h30, 6, 0, 0, 0);
		set_entry(5, "backward_loop", 64'h70, 12, 0, 0, 0);
		set_entry(6, "stall_window", 64'h40, 16, 3, 6, 0);
		set_entry(7, "stall_at_target", 64'h2c, 10, 1, 4, 0);
		set_entry(8, "mispredict_mid_stream", 64'h14, 8, 0, 0, 0);
		set_entry(9, "stall_long", 64'h58, 20, 5, 12, 0);
		// reset falls with the last write, so it is high for 16 edges
		for (int l = 0; l < PROGRAM_LINES; l++)
		begin
			@(posedge clock);
			mem_write_enable <= 1'b1;
			mem_write_addr   <= l[fetch_pkg::MEM_INDEX_BITS-1:0];
			mem_write_data   <= program_lines[l];
		end
		reset <= 1'b0;
		for (int i = 0; i < NUM_TESTS; i++)
		begin
			source = $unsigned($random(seed)) % 4;      // which stall input to use
			@(posedge clock);
			mem_write_enable <= 1'b0;
			mispredict       <= 1'b1;
			target_pc        <= starts[i];
			CHK.start_test(names[i]);
			@(posedge clock);
			mispredict <= 1'b0;
			cycle = 0;
			done = 1'b0;
			while (!done && cycle < TEST_TIMEOUT)
			begin
				@(posedge clock);
				cycle++;
				if (stall_len[i] > 0 && cycle == stall_at[i])
					drive_stall(source, 1'b1);
				if (stall_len[i] > 0 && cycle == stall_at[i] + stall_len[i])
					drive_stall(source, 1'b0);
				done = (CHK.observed >= counts[i]) && (cycle > stall_at[i] + stall_len[i]);
			end
			drive_stall(source, 1'b0);                  // window closed even on timeout
			CHK.finish_test(!done, counts[i], min_latency[i]);
		end
		@(posedge clock);
		CHK.report_counts();
		if (CHK.failed == 0 && CHK.error_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== sources.f ====
design/fetch_pkg.sv
design/fetch_ifs.sv
design/fetch_stage.sv
design/icache.sv
design/inst_memory.sv
design/branch_predecode.sv
design/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv
